//--- verilog/stack_pkg.sv
// Stack package: operation and status codes shared by the LIFO and its users
`default_nettype none

package stack_pkg;

  // Operation requested from a stack in one clock
  typedef enum logic [1:0] {
    ST_NONE    = 2'd0,  // Idle, status follows the limit
    ST_PUSH    = 2'd1,  // Write a new top entry
    ST_POP     = 2'd2,  // Remove the top entry
    ST_REPLACE = 2'd3   // Overwrite the top entry
  } stack_op_t;

  // Status reported after every clock
  typedef enum logic [1:0] {
    SS_OK        = 2'd0,  // Entries above the limit
    SS_EMPTY     = 2'd1,  // Depth sits exactly on the limit
    SS_UNDERFLOW = 2'd2,  // Pop/replace refused, or depth below limit
    SS_OVERFLOW  = 2'd3   // Push refused on a full stack
  } stack_status_t;

  // True for the two error codes
  function automatic logic is_error(stack_status_t s);
    return (s == SS_UNDERFLOW) || (s == SS_OVERFLOW);
  endfunction

endpackage

`default_nettype wire

//--- verilog/engine_pkg.sv
// Engine package: command codes, word and address types and the return frame
`default_nettype none

package engine_pkg;

  localparam int WORD_W  = 16;  // Data stack word
  localparam int ADDR_W  = 12;  // Return address
  localparam int LIMIT_W = 5;   // Saved limit, holds 0..16

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // One command per clock
  typedef enum logic [2:0] {
    CMD_NOP  = 3'd0,  // Idle
    CMD_LIT  = 3'd1,  // Push operand
    CMD_DROP = 3'd2,  // Pop data stack
    CMD_DUP  = 3'd3,  // Push copy of tos
    CMD_INC  = 3'd4,  // tos + 1 in place
    CMD_SET  = 3'd5,  // Overwrite tos with operand
    CMD_CALL = 3'd6,  // Push return frame, narrow the limit
    CMD_RET  = 3'd7   // Pop return frame, restore the limit
  } cmd_t;

  // Return stack entry
  typedef struct packed {
    addr_t              ret_addr;     // Where the caller resumes
    logic [LIMIT_W-1:0] saved_limit;  // Caller's underflow limit
  } ret_frame_t;

  // Commands that occupy two cycles
  function automatic logic is_frame_cmd(cmd_t c);
    return (c == CMD_CALL) || (c == CMD_RET);
  endfunction

endpackage

`default_nettype wire

//--- verilog/stack.sv
// Stack: generic LIFO with underflow limit, registered top of stack, depth and status
`timescale 1ns/10ps
`default_nettype none

module stack #(
  parameter int  DEPTH_LOG2 = 4,            // Capacity is 2**DEPTH_LOG2 entries
  parameter type payload_t  = logic [15:0]  // Entry type
) (
  input  wire                           clk,
  input  wire                           reset,
  input  wire stack_pkg::stack_op_t     op,     // Operation for this clock
  input  wire payload_t                 data,   // Value for push or replace
  input  wire [DEPTH_LOG2:0]            limit,  // Depth at or below which pops fail
  output payload_t                      tos,    // Current top entry
  output logic [DEPTH_LOG2:0]           depth,  // Entry count
  output stack_pkg::stack_status_t      status
);

  import stack_pkg::*;

  localparam int CAPACITY = 1 << DEPTH_LOG2;
  localparam int LW       = DEPTH_LOG2 + 1;

  localparam logic [LW-1:0] FULL_COUNT = LW'(CAPACITY);

  payload_t mem [CAPACITY];

  logic                  full;
  logic                  at_limit;   // Nothing poppable above the limit
  logic [LW-1:0]         depth_inc;
  logic [LW-1:0]         depth_dec;
  logic [DEPTH_LOG2-1:0] top_idx;    // Slot of the current top
  logic [DEPTH_LOG2-1:0] below_idx;  // Slot under the current top
  logic                  mem_we;
  logic [DEPTH_LOG2-1:0] mem_waddr;

  assign full      = (depth == FULL_COUNT);
  assign at_limit  = (depth <= limit);
  assign depth_inc = depth + 1'b1;
  assign depth_dec = depth - 1'b1;
  assign top_idx   = depth_dec[DEPTH_LOG2-1:0];
  assign below_idx = depth[DEPTH_LOG2-1:0] - 2'd2;

  // Push writes the next free slot, replace rewrites the top slot
  always_comb begin
    mem_we    = 1'b0;
    mem_waddr = depth[DEPTH_LOG2-1:0];
    case (op)
      ST_PUSH: begin
        mem_we    = !full;
        mem_waddr = depth[DEPTH_LOG2-1:0];
      end
      ST_REPLACE: begin
        mem_we    = !at_limit;
        mem_waddr = top_idx;
      end
      default: begin
        mem_we    = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_waddr] <= data;
    end
  end

  // Counter, top-of-stack register and status
  always_ff @(posedge clk) begin
    if (reset) begin
      depth  <= '0;
      tos    <= '0;
      status <= SS_EMPTY;
    end else begin
      case (op)
        ST_PUSH: begin
          if (full) begin
            status <= SS_OVERFLOW;  // Refused, contents kept
          end else begin
            depth  <= depth_inc;
            tos    <= data;
            status <= (depth_inc == limit) ? SS_EMPTY : SS_OK;
          end
        end

        ST_POP: begin
          if (at_limit) begin
            status <= SS_UNDERFLOW;
          end else begin
            depth  <= depth_dec;
            tos    <= mem[below_idx];  // Entry under the old top
            status <= (depth_dec == limit) ? SS_EMPTY : SS_OK;
          end
        end

        ST_REPLACE: begin
          if (at_limit) begin
            status <= SS_UNDERFLOW;
          end else begin
            tos    <= data;
            status <= SS_OK;  // Depth stays above the limit
          end
        end

        ST_NONE: begin
          // Limit may have moved under an idle stack
          if (depth < limit) begin
            status <= SS_UNDERFLOW;
          end else if (depth == limit) begin
            status <= SS_EMPTY;
          end else begin
            status <= SS_OK;
          end
        end
      endcase
    end
  end

  // Counter must stay within the array
  a_depth_bound: assert property (
    @(posedge clk) disable iff (reset)
    depth <= FULL_COUNT
  ) else $error("stack depth %0d beyond capacity %0d", depth, CAPACITY);

  // A refused operation leaves the entry count alone
  a_error_keeps_depth: assert property (
    @(posedge clk) disable iff (reset)
    is_error(status) |-> $stable(depth)
  ) else $error("stack depth moved while status is %s", status.name());

endmodule

`default_nettype wire

//--- verilog/engine_ctrl.sv
// Engine controller: command decode, frame-limit register and deferred call/return commit
`timescale 1ns/10ps
`default_nettype none

module engine_ctrl #(
  parameter int D_DEPTH_LOG2 = 4  // Data stack size
) (
  input  wire                             clk,
  input  wire                             reset,
  input  wire engine_pkg::cmd_t           cmd,
  input  wire engine_pkg::word_t          operand,
  input  wire engine_pkg::addr_t          call_addr,
  input  wire [D_DEPTH_LOG2:0]            arg_count,    // Words handed to the callee
  input  wire engine_pkg::word_t          d_tos,
  input  wire [D_DEPTH_LOG2:0]            d_depth,
  input  wire engine_pkg::ret_frame_t     r_tos,
  input  wire stack_pkg::stack_status_t   r_status,
  output stack_pkg::stack_op_t            d_op,
  output engine_pkg::word_t               d_data,
  output logic [D_DEPTH_LOG2:0]           frame_limit,  // Underflow limit of the data stack
  output stack_pkg::stack_op_t            r_op,
  output engine_pkg::ret_frame_t          r_data,
  output engine_pkg::addr_t               ret_addr,
  output logic                            ret_valid     // One-cycle pulse per RET
);

  import stack_pkg::*;
  import engine_pkg::*;

  localparam int LW = D_DEPTH_LOG2 + 1;

  logic [LW-1:0] call_limit;  // Callee limit, clamped at zero
  logic          pend_call;   // CALL waiting on return stack status
  logic          pend_ret;    // RET waiting on return stack status
  ret_frame_t    pend_frame;  // Candidate limit and return address

  assign call_limit = (d_depth > arg_count) ? (d_depth - arg_count) : '0;

  // Command decode
  always_comb begin
    d_op   = ST_NONE;
    d_data = operand;
    r_op   = ST_NONE;
    r_data = '{ret_addr: call_addr, saved_limit: LIMIT_W'(frame_limit)};
    case (cmd)
      CMD_LIT:  d_op = ST_PUSH;
      CMD_DROP: d_op = ST_POP;
      CMD_DUP: begin
        d_op   = ST_PUSH;
        d_data = d_tos;
      end
      CMD_INC: begin
        d_op   = ST_REPLACE;
        d_data = d_tos + 1'b1;
      end
      CMD_SET:  d_op = ST_REPLACE;
      CMD_CALL: r_op = ST_PUSH;   // Frame keeps the caller's limit
      CMD_RET:  r_op = ST_POP;
      default: begin
        d_op = ST_NONE;
      end
    endcase
  end

  // Capture the candidate now, the return stack answers next cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      pend_call <= 1'b0;
      pend_ret  <= 1'b0;
    end else begin
      pend_call <= (cmd == CMD_CALL);
      pend_ret  <= (cmd == CMD_RET);
    end
  end

  always_ff @(posedge clk) begin
    if (cmd == CMD_CALL) begin
      pend_frame <= '{ret_addr: call_addr, saved_limit: LIMIT_W'(call_limit)};
    end else if (cmd == CMD_RET) begin
      pend_frame <= r_tos;  // Popped frame, before the stack moves
    end
  end

  // Commit or discard based on r_status
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_limit <= '0;
      ret_valid   <= 1'b0;
    end else begin
      ret_valid <= 1'b0;
      if (pend_call && (r_status != SS_OVERFLOW)) begin
        frame_limit <= LW'(pend_frame.saved_limit);
      end
      if (pend_ret && (r_status != SS_UNDERFLOW)) begin
        frame_limit <= LW'(pend_frame.saved_limit);
        ret_valid   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pend_ret) begin
      ret_addr <= pend_frame.ret_addr;
    end
  end

  // Commit cycle of CALL/RET has no room for another command
  a_nop_after_frame: assert property (
    @(posedge clk) disable iff (reset)
    is_frame_cmd(cmd) |=> (cmd == CMD_NOP)
  ) else $error("command %s issued during CALL/RET commit", cmd.name());

  a_ret_pulse: assert property (
    @(posedge clk) disable iff (reset)
    ret_valid |=> !ret_valid
  ) else $error("ret_valid held longer than one cycle");

endmodule

`default_nettype wire

//--- verilog/stack_engine.sv
// Stack engine: controller driving a data stack and a return stack
`timescale 1ns/10ps
`default_nettype none

module stack_engine #(
  parameter int D_DEPTH_LOG2 = 4,  // 16 data words
  parameter int R_DEPTH_LOG2 = 3   // 8 return frames
) (
  input  wire                             clk,
  input  wire                             reset,
  input  wire engine_pkg::cmd_t           cmd,
  input  wire engine_pkg::word_t          operand,
  input  wire engine_pkg::addr_t          call_addr,
  input  wire [D_DEPTH_LOG2:0]            arg_count,
  output engine_pkg::word_t               tos,          // Data stack top
  output stack_pkg::stack_status_t        status,       // Data stack status
  output logic [D_DEPTH_LOG2:0]           depth,        // Data stack entries
  output logic [D_DEPTH_LOG2:0]           frame_limit,
  output stack_pkg::stack_status_t        rstatus,      // Return stack status
  output engine_pkg::addr_t               ret_addr,
  output logic                            ret_valid
);

  import stack_pkg::*;
  import engine_pkg::*;

  stack_op_t  d_op;
  word_t      d_data;
  stack_op_t  r_op;
  ret_frame_t r_data;
  ret_frame_t r_tos;

  engine_ctrl #(
    .D_DEPTH_LOG2 (D_DEPTH_LOG2)
  ) u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .cmd         (cmd),
    .operand     (operand),
    .call_addr   (call_addr),
    .arg_count   (arg_count),
    .d_tos       (tos),
    .d_depth     (depth),
    .r_tos       (r_tos),
    .r_status    (rstatus),
    .d_op        (d_op),
    .d_data      (d_data),
    .frame_limit (frame_limit),
    .r_op        (r_op),
    .r_data      (r_data),
    .ret_addr    (ret_addr),
    .ret_valid   (ret_valid)
  );

  // Data stack, bounded below by the frame limit
  stack #(
    .DEPTH_LOG2 (D_DEPTH_LOG2),
    .payload_t  (word_t)
  ) u_dstack (
    .clk    (clk),
    .reset  (reset),
    .op     (d_op),
    .data   (d_data),
    .limit  (frame_limit),
    .tos    (tos),
    .depth  (depth),
    .status (status)
  );

  // Return stack, the whole array is usable
  stack #(
    .DEPTH_LOG2 (R_DEPTH_LOG2),
    .payload_t  (ret_frame_t)
  ) u_rstack (
    .clk    (clk),
    .reset  (reset),
    .op     (r_op),
    .data   (r_data),
    .limit  ('0),
    .tos    (r_tos),
    .depth  (),
    .status (rstatus)
  );

endmodule

`default_nettype wire

//--- dv/stack_engine_tb.sv
// Stack engine testbench: seeded command stimulus checked against a queue model
`timescale 1ns/10ps
`default_nettype none

module stack_engine_tb;

  import stack_pkg::*;
  import engine_pkg::*;

  localparam int D_LOG2      = 4;
  localparam int R_LOG2      = 3;
  localparam int D_CAP       = 1 << D_LOG2;  // 16 data words
  localparam int R_CAP       = 1 << R_LOG2;  // 8 return frames
  localparam int RET_TIMEOUT = 10;           // Cycles allowed for the ret_valid pulse

  logic            clk;
  logic            reset;
  cmd_t            cmd;
  word_t           operand;
  addr_t           call_addr;
  logic [D_LOG2:0] arg_count;
  word_t           tos;
  stack_status_t   status;
  logic [D_LOG2:0] depth;
  logic [D_LOG2:0] frame_limit;
  stack_status_t   rstatus;
  addr_t           ret_addr;
  logic            ret_valid;

  integer seed;
  int     errors;
  int     timeouts;

  // Reference model, state after the edge that takes the current command
  word_t           m_data[$];
  ret_frame_t      m_ret[$];
  logic [D_LOG2:0] m_limit;
  stack_status_t   m_status;
  stack_status_t   m_rstatus;
  logic            m_pend_call;
  logic            m_pend_ret;
  logic [D_LOG2:0] m_pend_limit;
  addr_t           m_pend_addr;
  logic            m_ret_valid;
  addr_t           m_ret_addr;

  // Model outputs lined up with the DUT outputs
  word_t           chk_tos;
  logic            chk_tos_valid;
  logic [D_LOG2:0] chk_depth;
  stack_status_t   chk_status;
  logic [D_LOG2:0] chk_limit;
  stack_status_t   chk_rstatus;
  logic            chk_ret_valid;
  addr_t           chk_ret_addr;

  stack_engine #(
    .D_DEPTH_LOG2 (D_LOG2),
    .R_DEPTH_LOG2 (R_LOG2)
  ) UUT (
    .clk         (clk),
    .reset       (reset),
    .cmd         (cmd),
    .operand     (operand),
    .call_addr   (call_addr),
    .arg_count   (arg_count),
    .tos         (tos),
    .status      (status),
    .depth       (depth),
    .frame_limit (frame_limit),
    .rstatus     (rstatus),
    .ret_addr    (ret_addr),
    .ret_valid   (ret_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  always_ff @(posedge clk) begin
    chk_tos       <= (m_data.size() > 0) ? m_data[$] : '0;
    chk_tos_valid <= (m_data.size() > 0);  // Top of an empty stack is not defined
    chk_depth     <= (D_LOG2 + 1)'(m_data.size());
    chk_status    <= m_status;
    chk_limit     <= m_limit;
    chk_rstatus   <= m_rstatus;
    chk_ret_valid <= m_ret_valid;
    chk_ret_addr  <= m_ret_addr;
  end

  function automatic logic one_cycle_cmd(cmd_t c);
    return c inside {CMD_LIT, CMD_DROP, CMD_DUP, CMD_INC, CMD_SET};
  endfunction

  function automatic logic two_cycle_cmd(cmd_t c);
    return (c == CMD_CALL) || (c == CMD_RET);
  endfunction

  task automatic report_fail(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  // Data commands settle one cycle after their edge
  a_data_result: assert property (
    @(posedge clk) disable iff (reset)
    one_cycle_cmd(cmd) |=> (depth == chk_depth) && (status == chk_status) &&
                           (!chk_tos_valid || tos == chk_tos) &&
                           (frame_limit == chk_limit) && (ret_valid == chk_ret_valid)
  ) else report_fail($sformatf("data stack: tos %h depth %0d status %s, expected %h %0d %s",
                               tos, depth, status.name(), chk_tos, chk_depth,
                               chk_status.name()));

  a_frame_rstatus: assert property (
    @(posedge clk) disable iff (reset)
    two_cycle_cmd(cmd) |=> (rstatus == chk_rstatus)
  ) else report_fail($sformatf("rstatus %s, expected %s", rstatus.name(), chk_rstatus.name()));

  // Limit and return pulse appear after the commit edge
  a_frame_commit: assert property (
    @(posedge clk) disable iff (reset)
    two_cycle_cmd(cmd) |-> ##2 (frame_limit == chk_limit) && (ret_valid == chk_ret_valid) &&
                               (!chk_ret_valid || ret_addr == chk_ret_addr)
  ) else report_fail($sformatf("commit: limit %0d valid %b addr %h, expected %0d %b %h",
                               frame_limit, ret_valid, ret_addr, chk_limit, chk_ret_valid,
                               chk_ret_addr));

  task automatic model_step(input cmd_t c, input word_t opnd, input addr_t addr,
                            input logic [D_LOG2:0] args);
    int              dsize;
    logic [D_LOG2:0] old_limit;
    ret_frame_t      frame;
    dsize     = m_data.size();
    old_limit = m_limit;  // Data stack still sees the limit before this edge
    case (c)
      CMD_LIT, CMD_DUP: begin
        if (dsize == D_CAP) begin
          m_status = SS_OVERFLOW;
        end else begin
          m_data.push_back((c == CMD_LIT) ? opnd : m_data[dsize-1]);
          m_status = (dsize + 1 == old_limit) ? SS_EMPTY : SS_OK;
        end
      end
      CMD_DROP: begin
        if (dsize <= old_limit) begin
          m_status = SS_UNDERFLOW;
        end else begin
          void'(m_data.pop_back());
          m_status = (dsize - 1 == old_limit) ? SS_EMPTY : SS_OK;
        end
      end
      CMD_INC, CMD_SET: begin
        if (dsize <= old_limit) begin
          m_status = SS_UNDERFLOW;
        end else begin
          m_data[dsize-1] = (c == CMD_INC) ? word_t'(m_data[dsize-1] + 1) : opnd;
          m_status        = SS_OK;
        end
      end
      default: begin
        if (dsize < old_limit) m_status = SS_UNDERFLOW;
        else if (dsize == old_limit) m_status = SS_EMPTY;
        else m_status = SS_OK;
      end
    endcase
    // Commit of the CALL or RET taken one edge earlier
    m_ret_valid = 1'b0;
    if (m_pend_call && m_rstatus != SS_OVERFLOW) m_limit = m_pend_limit;
    if (m_pend_ret && m_rstatus != SS_UNDERFLOW) begin
      m_limit     = m_pend_limit;
      m_ret_valid = 1'b1;
      m_ret_addr  = m_pend_addr;
    end
    m_pend_call = (c == CMD_CALL);
    m_pend_ret  = (c == CMD_RET);
    if (c == CMD_CALL) begin
      m_pend_limit = (dsize > args) ? (D_LOG2 + 1)'(dsize - args) : '0;
      if (m_ret.size() == R_CAP) begin
        m_rstatus = SS_OVERFLOW;
      end else begin
        frame.ret_addr    = addr;
        frame.saved_limit = old_limit;
        m_ret.push_back(frame);
        m_rstatus = SS_OK;
      end
    end else if (c == CMD_RET) begin
      if (m_ret.size() == 0) begin
        m_rstatus = SS_UNDERFLOW;
      end else begin
        frame        = m_ret.pop_back();
        m_pend_limit = frame.saved_limit;
        m_pend_addr  = frame.ret_addr;
        m_rstatus    = (m_ret.size() == 0) ? SS_EMPTY : SS_OK;
      end
    end else begin
      m_rstatus = (m_ret.size() == 0) ? SS_EMPTY : SS_OK;
    end
  endtask

  // Drives one command 1 ns after an edge, returns 1 ns after the edge that takes it
  task automatic issue(input cmd_t c, input word_t opnd, input addr_t addr,
                       input logic [D_LOG2:0] args);
    cmd       = c;
    operand   = opnd;
    call_addr = addr;
    arg_count = args;
    model_step(c, opnd, addr, args);
    @(posedge clk);
    #1;
  endtask

  task automatic data_cmd(input cmd_t c);
    issue(c, word_t'($random(seed)), '0, '0);
  endtask

  task automatic do_call(input addr_t addr, input logic [D_LOG2:0] args);
    issue(CMD_CALL, '0, addr, args);
    issue(CMD_NOP, '0, '0, '0);  // Commit cycle
  endtask

  task automatic do_ret(input logic expect_pulse, input addr_t want);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    issue(CMD_RET, '0, '0, '0);
    if (!expect_pulse) begin
      issue(CMD_NOP, '0, '0, '0);
    end else begin
      while (!seen && waited < RET_TIMEOUT) begin
        issue(CMD_NOP, '0, '0, '0);
        waited++;
        if (ret_valid) begin
          seen = 1'b1;
          assert (ret_addr == want)
            else report_fail($sformatf("return order: got %h, expected %h", ret_addr, want));
        end
      end
      if (!seen) begin
        timeouts++;
        $display("Timeout: no ret_valid pulse within %0d cycles after RET", RET_TIMEOUT);
      end
    end
  endtask

  initial begin
    addr_t           addrs[R_CAP+1];
    logic [D_LOG2:0] args;
    seed         = 96;
    errors       = 0;
    timeouts     = 0;
    reset        = 1'b1;
    cmd          = CMD_NOP;
    operand      = '0;
    call_addr    = '0;
    arg_count    = '0;
    m_limit      = '0;
    m_status     = SS_EMPTY;
    m_rstatus    = SS_EMPTY;
    m_pend_call  = 1'b0;
    m_pend_ret   = 1'b0;
    m_pend_limit = '0;
    m_pend_addr  = '0;
    m_ret_valid  = 1'b0;
    m_ret_addr   = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    repeat (5) data_cmd(CMD_LIT);            // Count up, then unwind in reverse
    repeat (5) data_cmd(CMD_DROP);
    repeat (D_CAP + 1) data_cmd(CMD_LIT);    // Last push overflows
    repeat (D_CAP) data_cmd(CMD_DROP);
    data_cmd(CMD_DROP);                      // Underflow on empty
    data_cmd(CMD_LIT);
    data_cmd(CMD_DUP);
    data_cmd(CMD_INC);
    data_cmd(CMD_SET);
    repeat (2) data_cmd(CMD_DROP);

    repeat (6) data_cmd(CMD_LIT);
    args = (D_LOG2 + 1)'($unsigned($random(seed)) % 8);
    do_call(12'h3a0, args);
    repeat (2) data_cmd(CMD_LIT);
    repeat (12) data_cmd(CMD_DROP);          // Runs into the callee limit
    data_cmd(CMD_SET);
    do_ret(1'b1, 12'h3a0);
    do_call(12'h3b4, (D_LOG2 + 1)'(m_data.size() + 3));  // Clamped at zero
    do_ret(1'b1, 12'h3b4);
    while (m_data.size() > 0) data_cmd(CMD_DROP);

    repeat (2) data_cmd(CMD_LIT);
    for (int i = 0; i < 3; i++) begin
      addrs[i] = addr_t'($random(seed));
      do_call(addrs[i], 1);
      data_cmd(CMD_LIT);
    end
    for (int i = 2; i >= 0; i--) begin
      do_ret(1'b1, addrs[i]);
      data_cmd(CMD_DROP);
    end

    do_ret(1'b0, '0);                        // Empty return stack
    for (int i = 0; i <= R_CAP; i++) begin
      addrs[i] = addr_t'($random(seed));
      data_cmd(CMD_LIT);
      do_call(addrs[i], 1);                  // Ninth call overflows
    end
    for (int i = R_CAP - 1; i >= 0; i--) do_ret(1'b1, addrs[i]);
    repeat (2) issue(CMD_NOP, '0, '0, '0);

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
verilog/stack_pkg.sv
verilog/engine_pkg.sv
verilog/stack.sv
verilog/engine_ctrl.sv
verilog/stack_engine.sv
dv/stack_engine_tb.sv

//--- run.sh
#!/bin/sh
# Build the stack engine testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module stack_engine_tb \
  -f compile.f -o sim_stack_engine \
  && ./obj_dir/sim_stack_engine > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "Simulation FAILED"; exit 1; } \
  || { echo "Simulation PASSED"; exit 0; }
